// File: source/eeprom_pkg.sv
package eeprom_pkg;

    // host request type
    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } op_t;

    typedef enum logic [3:0] {
        IDLE,
        START,
        CTRL_WR,
        ADDR,
        DATA_WR,
        RESTART,
        CTRL_RD,
        DATA_RD,
        STOP,
        DONE
    } seq_state_t;

    // a repeated start is just COND_START issued mid-transfer
    typedef enum logic {
        COND_START,
        COND_STOP
    } cond_t;

    // scl quarter phases, scl high in the two HIGH phases
    typedef enum logic [1:0] {
        PH_LOW_A,
        PH_LOW_B,
        PH_HIGH_A,
        PH_HIGH_B
    } phase_t;

    localparam logic [3:0] DEV_CODE = 4'b1010;   // 24Cxx device type
    localparam int         ADDR_W   = 11;
    localparam int         DATA_W   = 8;

endpackage

// File: source/eeprom_bus_if.sv
`timescale 1ns/100ps

// sequencer <-> start/stop generator
interface bus_cond_if import eeprom_pkg::*; ();
    logic   go;       // one-cycle request
    cond_t  kind;
    phase_t phase;
    logic   done;     // one-cycle completion
    logic   drive;    // generator owns sda
    logic   level;    // requested sda level while driving

    modport controller (output go, kind, phase, input done, drive, level);
    modport generator  (input go, kind, phase, output done, drive, level);
endinterface

// sequencer <-> byte shifter
interface byte_xfer_if import eeprom_pkg::*; ();
    logic              go;
    logic              rx;            // 1 = receive from slave
    logic [DATA_W-1:0] tx_byte;
    logic              master_nack;   // ninth bit level after a receive
    phase_t            phase;
    logic              done;
    logic [DATA_W-1:0] rx_byte;
    logic              slave_nack;
    logic              drive;
    logic              level;

    modport controller (
        output go, rx, tx_byte, master_nack, phase,
        input  done, rx_byte, slave_nack, drive, level
    );
    modport shifter (
        input  go, rx, tx_byte, master_nack, phase,
        output done, rx_byte, slave_nack, drive, level
    );
endinterface

// File: source/bus_cond_gen.sv
`timescale 1ns/100ps

module bus_cond_gen import eeprom_pkg::*; (
    input  logic          CLK,
    input  logic          RESET,
    bus_cond_if.generator cond,
    input  logic          sda_in
);

    phase_t ph_q;
    logic   armed;     // go seen, waiting for scl high
    logic   pend;      // start edge held back until sda reads high
    logic   low_entry;
    logic   high_entry;
    logic   scl_high;

    assign low_entry  = (cond.phase == PH_LOW_A) && (ph_q != PH_LOW_A);
    assign high_entry = (cond.phase == PH_HIGH_A) && (ph_q != PH_HIGH_A);
    assign scl_high   = (cond.phase == PH_HIGH_A) || (cond.phase == PH_HIGH_B);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            ph_q       <= PH_HIGH_B;
            armed      <= 1'b0;
            pend       <= 1'b0;
            cond.drive <= 1'b0;
            cond.level <= 1'b1;
            cond.done  <= 1'b0;
        end else begin
            ph_q      <= cond.phase;
            cond.done <= 1'b0;
            if (cond.go) begin
                cond.drive <= 1'b1;
                cond.level <= (cond.kind == COND_START);   // low half: release for start
                armed      <= 1'b1;
                pend       <= 1'b0;
            end else if (armed && high_entry) begin
                armed     <= 1'b0;
                cond.done <= 1'b1;
                if (cond.kind == COND_STOP) begin
                    cond.level <= 1'b1;   // sda rises with scl high
                end else if (sda_in) begin
                    cond.level <= 1'b0;   // sda falls with scl high
                end else begin
                    pend <= 1'b1;
                end
            end else if (pend && scl_high && sda_in) begin
                cond.level <= 1'b0;
                pend       <= 1'b0;
            end else if (low_entry) begin
                cond.drive <= 1'b0;   // next part has taken the line
                pend       <= 1'b0;
            end
        end
    end

endmodule

// File: source/byte_shifter.sv
`timescale 1ns/100ps

module byte_shifter import eeprom_pkg::*; (
    input  logic         CLK,
    input  logic         RESET,
    byte_xfer_if.shifter xfer,
    input  logic         sda_in
);

    phase_t            ph_q;
    logic              busy;
    logic [3:0]        bitcnt;   // 0..7 data, 8 = acknowledge bit
    logic [DATA_W-1:0] sreg;
    logic              low_entry;
    logic              high_entry;

    // each phase boundary is seen one cycle after the sequencer moves
    assign low_entry  = (xfer.phase == PH_LOW_A) && (ph_q != PH_LOW_A);
    assign high_entry = (xfer.phase == PH_HIGH_A) && (ph_q != PH_HIGH_A);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            ph_q            <= PH_HIGH_B;
            busy            <= 1'b0;
            bitcnt          <= 4'd0;
            sreg            <= '0;
            xfer.drive      <= 1'b0;
            xfer.level      <= 1'b1;
            xfer.done       <= 1'b0;
            xfer.slave_nack <= 1'b0;
            xfer.rx_byte    <= '0;
        end else begin
            ph_q      <= xfer.phase;
            xfer.done <= 1'b0;

            if (xfer.go) begin
                busy       <= 1'b1;
                bitcnt     <= 4'd0;
                sreg       <= xfer.tx_byte;
                xfer.drive <= 1'b1;
                // receive releases sda for the data bits
                xfer.level <= xfer.rx || xfer.tx_byte[DATA_W-1];
            end else if (busy && high_entry) begin
                if (bitcnt == 4'd8) begin
                    xfer.done       <= 1'b1;
                    xfer.slave_nack <= !xfer.rx && sda_in;   // released line = nack
                    xfer.rx_byte    <= sreg;
                end else if (xfer.rx) begin
                    sreg <= {sreg[DATA_W-2:0], sda_in};
                end
            end else if (busy && low_entry) begin
                if (bitcnt == 4'd8) begin
                    busy       <= 1'b0;
                    xfer.drive <= 1'b0;
                end else begin
                    bitcnt <= bitcnt + 4'd1;
                    if (bitcnt == 4'd7) begin
                        // ack slot: master answers on a read, listens on a write
                        xfer.level <= xfer.rx ? xfer.master_nack : 1'b1;
                    end else if (!xfer.rx) begin
                        sreg       <= {sreg[DATA_W-2:0], 1'b0};
                        xfer.level <= sreg[DATA_W-2];
                    end
                end
            end
        end
    end

endmodule

// File: source/eeprom_sequencer.sv
`timescale 1ns/100ps

module eeprom_sequencer import eeprom_pkg::*; #(
    parameter int SCL_QUARTER = 2
) (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              req,
    input  op_t               op,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    output logic [DATA_W-1:0] rdata,
    output logic              ack,
    output logic              err,
    output logic              scl,
    output logic              sda_low,
    bus_cond_if.controller    cond,
    byte_xfer_if.controller   xfer
);

    localparam int QW = (SCL_QUARTER > 1) ? $clog2(SCL_QUARTER) : 1;

    seq_state_t        state;
    phase_t            phase;
    logic [QW-1:0]     qcnt;
    logic              quarter_end;
    logic              period_end;
    logic              run;
    logic              sub_done;   // current part reported done
    logic              fin;
    logic              step;       // move on at the end of this scl period
    logic              issue;
    logic [DATA_W-1:0] ctrl_byte;

    assign run         = (state != IDLE) && (state != DONE);
    assign quarter_end = (qcnt == QW'(SCL_QUARTER - 1));
    assign period_end  = run && quarter_end && (phase == PH_HIGH_B);
    assign fin         = sub_done || cond.done || xfer.done;
    assign step        = period_end && fin;
    assign issue       = step || ((state == IDLE) && req);

    // r/w bit set only for the control byte after the repeated start
    assign ctrl_byte = {DEV_CODE, addr[ADDR_W-1:DATA_W], state == RESTART};

    assign cond.phase       = phase;
    assign xfer.phase       = phase;
    assign xfer.master_nack = 1'b1;   // single-byte read always ends in nack

    // wired-and of whichever parts currently own sda
    assign sda_low = (cond.drive && !cond.level) || (xfer.drive && !xfer.level);

    // scl quarter-phase generator, parked high between transfers
    always_ff @(posedge CLK) begin
        if (RESET) begin
            qcnt  <= '0;
            phase <= PH_HIGH_B;
            scl   <= 1'b1;
        end else if ((state == IDLE) && req) begin
            qcnt  <= '0;
            phase <= PH_LOW_A;
            scl   <= 1'b0;
        end else if (run) begin
            if (quarter_end) begin
                qcnt <= '0;
                if (!(period_end && (state == STOP))) begin
                    phase <= phase_t'(phase + 2'd1);
                    scl   <= (phase == PH_LOW_B) || (phase == PH_HIGH_A);
                end
            end else begin
                qcnt <= qcnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state        <= IDLE;
            ack          <= 1'b0;
            err          <= 1'b0;
            rdata        <= '0;
            sub_done     <= 1'b0;
            cond.go      <= 1'b0;
            cond.kind    <= COND_START;
            xfer.go      <= 1'b0;
            xfer.rx      <= 1'b0;
            xfer.tx_byte <= '0;
        end else begin
            cond.go  <= 1'b0;
            xfer.go  <= 1'b0;
            sub_done <= fin && !issue;

            case (state)
                IDLE: begin
                    if (req) begin
                        err       <= 1'b0;
                        cond.go   <= 1'b1;
                        cond.kind <= COND_START;
                        state     <= START;
                    end
                end
                START, RESTART: begin
                    if (step) begin
                        xfer.go      <= 1'b1;
                        xfer.rx      <= 1'b0;
                        xfer.tx_byte <= ctrl_byte;
                        state        <= (state == START) ? CTRL_WR : CTRL_RD;
                    end
                end
                CTRL_WR, ADDR, DATA_WR, CTRL_RD: begin
                    if (step) begin
                        if (xfer.slave_nack || (state == DATA_WR)) begin
                            err       <= xfer.slave_nack;   // any nack aborts
                            cond.go   <= 1'b1;
                            cond.kind <= COND_STOP;
                            state     <= STOP;
                        end else if (state == CTRL_WR) begin
                            xfer.go      <= 1'b1;
                            xfer.tx_byte <= addr[DATA_W-1:0];
                            state        <= ADDR;
                        end else if (state == CTRL_RD) begin
                            xfer.go <= 1'b1;
                            xfer.rx <= 1'b1;
                            state   <= DATA_RD;
                        end else if (op == OP_WRITE) begin
                            xfer.go      <= 1'b1;
                            xfer.tx_byte <= wdata;
                            state        <= DATA_WR;
                        end else begin
                            cond.go   <= 1'b1;
                            cond.kind <= COND_START;   // repeated start
                            state     <= RESTART;
                        end
                    end
                end
                DATA_RD: begin
                    if (step) begin
                        rdata     <= xfer.rx_byte;
                        cond.go   <= 1'b1;
                        cond.kind <= COND_STOP;
                        state     <= STOP;
                    end
                end
                STOP: begin
                    if (step) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    if (req) begin
                        ack <= 1'b1;
                    end else begin
                        ack   <= 1'b0;   // four-phase return to zero
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: source/eeprom_ctrl.sv
`timescale 1ns/100ps

module eeprom_ctrl import eeprom_pkg::*; #(
    parameter int SCL_QUARTER = 2   // clk cycles per quarter scl period
) (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              req,
    input  op_t               op,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    output logic [DATA_W-1:0] rdata,
    output logic              ack,
    output logic              err,
    output logic              scl,
    output logic              sda_low,   // high pulls sda to 0
    input  logic              sda_in
);

    bus_cond_if  cond_bus ();
    byte_xfer_if xfer_bus ();

    eeprom_sequencer #(
        .SCL_QUARTER (SCL_QUARTER)
    ) seq0 (
        .CLK     (CLK),
        .RESET   (RESET),
        .req     (req),
        .op      (op),
        .addr    (addr),
        .wdata   (wdata),
        .rdata   (rdata),
        .ack     (ack),
        .err     (err),
        .scl     (scl),
        .sda_low (sda_low),
        .cond    (cond_bus.controller),
        .xfer    (xfer_bus.controller)
    );

    bus_cond_gen cond0 (
        .CLK    (CLK),
        .RESET  (RESET),
        .cond   (cond_bus.generator),
        .sda_in (sda_in)
    );

    byte_shifter shift0 (
        .CLK    (CLK),
        .RESET  (RESET),
        .xfer   (xfer_bus.shifter),
        .sda_in (sda_in)
    );

endmodule

// File: test/eeprom_model.sv
`timescale 1ns/100ps

module eeprom_model (
    input  logic scl,
    input  logic sda,
    input  logic present,   // low makes the device ignore its address
    output logic sda_low
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_WDATA,
        M_RDATA
    } mstate_t;

    logic [7:0]  mem [0:2047];
    mstate_t     state    = M_IDLE;
    logic [3:0]  bit_cnt  = 4'd0;
    logic        ack_slot = 1'b0;   // slave owns the ninth bit
    logic [7:0]  sreg     = 8'h00;
    logic [10:0] ptr      = 11'h000;
    logic        low_q    = 1'b0;
    logic        scl_q    = 1'b1;
    logic        sda_q    = 1'b1;

    assign sda_low = low_q;

    initial begin
        for (int i = 0; i < 2048; i++) begin
            mem[i] = 8'(i) ^ {i[10:8], i[10:8], i[9:8]};   // all address bits in the pattern
        end
    end

    always @(posedge scl or negedge scl or posedge sda or negedge sda) begin
        if (scl !== scl_q) begin
            if (scl && !ack_slot) begin
                if (state == M_RDATA) begin
                    if (bit_cnt == 4'd8) begin
                        state = M_IDLE;   // master ack bit, single-byte reads only
                    end else begin
                        sreg    = {sreg[6:0], 1'b0};
                        bit_cnt = bit_cnt + 4'd1;
                    end
                end else if (state != M_IDLE && bit_cnt != 4'd8) begin
                    sreg    = {sreg[6:0], sda};
                    bit_cnt = bit_cnt + 4'd1;
                end
            end else if (!scl) begin
                if (ack_slot) begin
                    ack_slot = 1'b0;
                    bit_cnt  = 4'd0;
                    if (state == M_RDATA) begin
                        sreg   = mem[ptr];
                        low_q <= !mem[ptr][7];
                    end else begin
                        low_q <= 1'b0;
                    end
                end else if (state == M_RDATA) begin
                    low_q <= (bit_cnt != 4'd8) && !sreg[7];   // let go for the master ack
                end else if (state != M_IDLE && bit_cnt == 4'd8) begin
                    ack_slot = 1'b1;
                    low_q   <= 1'b1;
                    case (state)
                        M_CTRL: begin
                            if (present && sreg[7:4] == 4'b1010) begin
                                ptr[10:8] = sreg[3:1];
                                state     = sreg[0] ? M_RDATA : M_ADDR;
                            end else begin
                                ack_slot = 1'b0;
                                low_q   <= 1'b0;   // not us, stay off the bus
                                state    = M_IDLE;
                            end
                        end
                        M_ADDR: begin
                            ptr[7:0] = sreg;
                            state    = M_WDATA;
                        end
                        default: mem[ptr] = sreg;   // write completes at once
                    endcase
                end
            end
        end else if (scl && sda !== sda_q) begin
            // sda moving with scl high: falling is start, rising is stop
            state    = sda ? M_IDLE : M_CTRL;
            bit_cnt  = 4'd0;
            ack_slot = 1'b0;
            low_q   <= 1'b0;
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

// File: test/tb_eeprom_ctrl.sv
`timescale 1ns/100ps

module tb_eeprom_ctrl import eeprom_pkg::*; ();

    localparam int SCL_Q       = 2;
    localparam int CLK_NS      = 8;
    localparam int WATCHDOG_NS = 2 * 20 * 39 * 4 * SCL_Q * CLK_NS;

    logic              CLK;
    logic              RESET;
    logic              req;
    op_t               op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;
    logic              ack;
    logic              err;
    logic              scl;
    logic              sda_low;
    logic              model_low;
    logic              present;
    wire               sda;
    logic [15:0]       lfsr;
    logic [DATA_W-1:0] exp_mem [0:2047];

    assign sda = !(sda_low || model_low);   // open drain, pulled up

    eeprom_ctrl #(
        .SCL_QUARTER (SCL_Q)
    ) dut0 (
        .CLK     (CLK),
        .RESET   (RESET),
        .req     (req),
        .op      (op),
        .addr    (addr),
        .wdata   (wdata),
        .rdata   (rdata),
        .ack     (ack),
        .err     (err),
        .scl     (scl),
        .sda_low (sda_low),
        .sda_in  (sda)
    );

    eeprom_model mem0 (
        .scl     (scl),
        .sda     (sda),
        .present (present),
        .sda_low (model_low)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_NS / 2) CLK = ~CLK;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16+x^14+x^13+x^11+1
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, want);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    // full four-phase handshake, called and returning on a falling edge
    task automatic host_xact(input op_t o, input logic [ADDR_W-1:0] a,
                             input logic [DATA_W-1:0] d, input int hold,
                             output logic [DATA_W-1:0] rd, output logic e);
        op    = o;
        addr  = a;
        wdata = d;
        req   = 1'b1;
        do begin
            @(negedge CLK);
        end while (ack !== 1'b1);
        rd = rdata;
        e  = err;
        repeat (hold) begin
            @(negedge CLK);
            compare("ack", 32'(ack), 32'h1);   // held while req is up
        end
        req = 1'b0;
        @(negedge CLK);
        compare("ack", 32'(ack), 32'h0);
    endtask

    task automatic write_byte(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        logic [DATA_W-1:0] rd;
        logic              e;
        host_xact(OP_WRITE, a, d, 0, rd, e);
        compare("err", 32'(e), 32'h0);
        exp_mem[a] = d;
    endtask

    task automatic read_expect(input logic [ADDR_W-1:0] a);
        logic [DATA_W-1:0] rd;
        logic              e;
        host_xact(OP_READ, a, 8'h00, 0, rd, e);
        compare("err", 32'(e), 32'h0);
        compare("rdata", 32'(rd), 32'(exp_mem[a]));
    endtask

    task automatic check_reset_state();
        compare("ack", 32'(ack), 32'h0);
        compare("err", 32'(err), 32'h0);
        repeat (40) begin
            compare("sda_low", 32'(sda_low), 32'h0);
            compare("scl", 32'(scl), 32'h1);   // bus parked while idle
            compare("ack", 32'(ack), 32'h0);
            @(negedge CLK);
        end
    endtask

    task automatic write_read_back();
        write_byte(11'h123, 8'h3C);
        read_expect(11'h123);
    endtask

    // same low byte, different block select bits
    task automatic upper_addr_bits();
        write_byte(11'h0A5, 8'h11);
        write_byte(11'h7A5, 8'hEE);
        read_expect(11'h0A5);
        read_expect(11'h7A5);
    endtask

    task automatic random_traffic();
        logic [ADDR_W-1:0] a [10];
        logic [15:0]       r;
        for (int k = 0; k < 10; k++) begin
            r    = rand_bits(ADDR_W);
            a[k] = r[ADDR_W-1:0];
            r    = rand_bits(DATA_W);
            write_byte(a[k], r[DATA_W-1:0]);
        end
        for (int k = 0; k < 10; k++) begin
            read_expect(a[k]);
        end
    endtask

    task automatic handshake_rules();
        logic [DATA_W-1:0] rd;
        logic              e;
        host_xact(OP_WRITE, 11'h35C, 8'hC3, 5, rd, e);
        compare("err", 32'(e), 32'h0);
        exp_mem[11'h35C] = 8'hC3;
        host_xact(OP_READ, 11'h35C, 8'h00, 3, rd, e);   // req again right after ack fell
        compare("err", 32'(e), 32'h0);
        compare("rdata", 32'(rd), 32'(exp_mem[11'h35C]));
        repeat (10) begin
            @(negedge CLK);
            compare("ack", 32'(ack), 32'h0);
            compare("scl", 32'(scl), 32'h1);
        end
    endtask

    task automatic missing_device();
        logic [DATA_W-1:0] rd;
        logic              e;
        present = 1'b0;
        host_xact(OP_WRITE, 11'h0A5, 8'h99, 0, rd, e);
        compare("err", 32'(e), 32'h1);
        host_xact(OP_READ, 11'h0A5, 8'h00, 0, rd, e);
        compare("err", 32'(e), 32'h1);
        present = 1'b1;
        read_expect(11'h0A5);   // failed write left the old byte
        read_expect(11'h123);
    endtask

    initial begin
        RESET   = 1'b1;
        req     = 1'b0;
        op      = OP_WRITE;
        addr    = '0;
        wdata   = '0;
        present = 1'b1;
        lfsr    = 16'd59642;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;

        check_reset_state();
        write_read_back();
        upper_addr_bits();
        random_traffic();
        handshake_rules();
        missing_device();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: all.f
source/eeprom_pkg.sv
source/eeprom_bus_if.sv
source/bus_cond_gen.sv
source/byte_shifter.sv
source/eeprom_sequencer.sv
source/eeprom_ctrl.sv
test/eeprom_model.sv
test/tb_eeprom_ctrl.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_eeprom_ctrl
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass message shows up in the output
run: compile
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)
